//--- common/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// PC loaded when reset is released
`define RV_RESET_PC     32'd44

// Interrupt handler entry point
`define RV_TRAP_VECTOR  32'd0

// Console output register, memory mapped
`define RV_CONSOLE_ADDR 64'h0000_0000_8000_0000

// Vector value that requests the one supported interrupt
`define RV_IRQ_LINE     4'd1

// Integer register count, x0 included
`define RV_NUM_REGS     32

`endif

//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Opcode classes the execute unit knows about
    typedef enum logic [1:0] {
        OP_NONE, // Anything unsupported, retires as a no-op
        OP_LUI,  // Load upper immediate
        OP_RET,  // All-zero word, back to saved PC
        OP_PUT   // All-ones opcode, console write of rs2
    } op_e;

    // Instruction register contents
    typedef struct packed {
        logic [31:0] instr;
        logic        valid;  // Low only in first cycle out of reset
    } fetch_t;

    // Trap request toward the execute unit
    typedef struct packed {
        logic        take;       // Jump to trap vector this edge
        logic [31:0] return_pc;  // PC saved at last taken trap
    } trap_t;

    // Outgoing bus write, strobe only
    typedef struct packed {
        logic [63:0] address;
        logic [63:0] write_data;
        logic        write_enable;
    } bus_req_t;

endpackage

`default_nettype wire

//--- core/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module exec_unit (
    input  wire logic          clk,
    input  wire logic          reset,    // Active low
    input  wire rv_pkg::fetch_t fetch,   // Instruction register
    input  wire rv_pkg::trap_t  trap,    // Interrupt entry request
    output logic [31:0]        pc,
    output logic               bubble,   // Discard the word now in IR
    output logic               put_ack,  // OP_PUT retiring this cycle
    output rv_pkg::bus_req_t   bus
);
    import rv_pkg::*;

    // Decoded fields
    logic [31:0] ir;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [63:0] imm_u;     // Upper immediate, sign extended
    op_e         op;
    logic        exec_ok;   // IR content retires this cycle
    logic [63:0] rs2_data;

    // 32 x 64 integer registers, x0 never written
    logic [63:0] regs [`RV_NUM_REGS];

    // Bus output registers
    logic [63:0] bus_addr_q;
    logic [63:0] bus_data_q;
    logic        bus_we_q;

    assign ir    = fetch.instr;
    assign rd    = ir[11:7];
    assign rs2   = ir[24:20];
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};

    // Opcode class
    always_comb begin
        casez (ir)
            32'b????????????????????_?????_0110111: op = OP_LUI;
            32'b00000000000000000000_00000_0000000: op = OP_RET;
            32'b????????????????????_?????_1111111: op = OP_PUT;
            default:                                op = OP_NONE;
        endcase
    end

    // Nothing retires on the first cycle, in a bubble,
    // or when an interrupt steals the slot
    assign exec_ok = fetch.valid && !bubble && !trap.take;

    assign put_ack = exec_ok && (op == OP_PUT);

    // x0 reads as zero
    assign rs2_data = (rs2 == 5'd0) ? 64'd0 : regs[rs2];

    // Register file write port
    always_ff @(posedge clk) begin
        if (exec_ok && (op == OP_LUI) && (rd != 5'd0)) begin
            regs[rd] <= imm_u;
        end
    end

    // PC and bubble
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc     <= `RV_RESET_PC;
            bubble <= 1'b0;
        end else if (trap.take) begin
            // Interrupt wins over the word in IR
            pc     <= `RV_TRAP_VECTOR;
            bubble <= 1'b1;
        end else if (exec_ok && (op == OP_RET)) begin
            pc     <= trap.return_pc;  // Back to interrupted code
            bubble <= 1'b1;
        end else begin
            pc     <= pc + 32'd4;      // Default sequential step
            bubble <= 1'b0;            // Flush done, if there was one
        end
    end

    // Write strobe, one cycle per put
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            bus_we_q <= 1'b0;
        end else begin
            bus_we_q <= put_ack;
        end
    end

    // Address and data only move on a put
    always_ff @(posedge clk) begin
        if (put_ack) begin
            bus_addr_q <= `RV_CONSOLE_ADDR;
            bus_data_q <= rs2_data;
        end
    end

    assign bus = '{
        address:      bus_addr_q,
        write_data:   bus_data_q,
        write_enable: bus_we_q
    };

    // Plain strobe, never held over
    a_we_single: assert property (
        @(posedge clk) disable iff (!reset)
        bus.write_enable |=> !bus.write_enable
    ) else $error("bus write_enable high for two cycles");

    // One flush per jump, unless a new trap lands in between
    a_bubble_once: assert property (
        @(posedge clk) disable iff (!reset)
        (bubble && !trap.take) |=> !bubble
    ) else $error("bubble set twice in a row without a trap");

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire logic        clk,
    input  wire logic        reset,        // Active low
    input  wire logic [31:0] instruction,  // One new word per clock
    output rv_pkg::fetch_t   fetch,
    output logic             heartbeat     // Toggles every cycle
);

    logic [31:0] instr_q;  // Instruction register
    logic        valid_q;
    logic        beat_q;

    // Instruction register loads every edge
    always_ff @(posedge clk) begin
        instr_q <= instruction;
    end

    // Control side of the fetch register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_q <= 1'b0;
            beat_q  <= 1'b0;
        end else begin
            valid_q <= 1'b1;     // First word is in after one edge
            beat_q  <= ~beat_q;  // Sign of life
        end
    end

    assign fetch = '{
        instr: instr_q,
        valid: valid_q
    };

    assign heartbeat = beat_q;

endmodule

`default_nettype wire

//--- hdl/riscv64_top.sv
`timescale 1ns/1ps
`default_nettype none

module riscv64_top (
    input  wire logic        clk,
    input  wire logic        reset,        // Active low, async
    input  wire logic [31:0] instruction,  // Fetched word from outside
    input  wire logic [3:0]  irq_vector,
    output logic [31:0]      pc,
    output logic             heartbeat,
    output rv_pkg::bus_req_t bus           // Console write, no handshake
);
    import rv_pkg::*;

    fetch_t fetch;    // IR toward execute
    trap_t  trap;     // Trap decision toward execute
    logic   bubble;   // Execute flush, holds off traps
    logic   put_ack;  // Handler acknowledge

    // Instruction register and heartbeat
    fetch_stage fetch_i (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .fetch       (fetch),
        .heartbeat   (heartbeat)
    );

    // Interrupt acceptance and return PC
    trap_ctrl trap_i (
        .clk        (clk),
        .reset      (reset),
        .irq_vector (irq_vector),
        .pc         (pc),
        .bubble     (bubble),
        .put_ack    (put_ack),
        .trap       (trap)
    );

    // Decode, registers, PC and bus
    exec_unit exec_i (
        .clk     (clk),
        .reset   (reset),
        .fetch   (fetch),
        .trap    (trap),
        .pc      (pc),
        .bubble  (bubble),
        .put_ack (put_ack),
        .bus     (bus)
    );

endmodule

`default_nettype wire

//--- hdl/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module trap_ctrl (
    input  wire logic        clk,
    input  wire logic        reset,       // Active low
    input  wire logic [3:0]  irq_vector,  // Only RV_IRQ_LINE is served
    input  wire logic [31:0] pc,          // Current PC from execute unit
    input  wire logic        bubble,      // Flush cycle in execute unit
    input  wire logic        put_ack,     // Handler acknowledge via put
    output rv_pkg::trap_t    trap
);

    logic        pending;    // Interrupt in service, blocks nesting
    logic        take;
    logic [31:0] return_pc;

    // Request accepted only outside a flush and when idle
    assign take = (irq_vector == `RV_IRQ_LINE) && !pending && !bubble;

    // Pending flag
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pending <= 1'b0;
        end else if (take) begin
            pending <= 1'b1;
        end else if (put_ack) begin
            pending <= 1'b0;  // Handler is done
        end
    end

    // Return address, captured once per taken trap
    always_ff @(posedge clk) begin
        if (take) begin
            return_pc <= pc;
        end
    end

    assign trap = '{
        take:      take,
        return_pc: return_pc
    };

    // A taken trap holds off any further take on the next cycle
    // and leaves the pending flag raised
    a_no_nested_take: assert property (
        @(posedge clk) disable iff (!reset)
        trap.take |=> (pending && !trap.take)
    ) else $error("trap taken again while interrupt pending");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f src.f --top-module tb_riscv64 \
        -Mdir obj_dir -o sim_riscv64 \
    && ./obj_dir/sim_riscv64 2>&1 | tee sim.log \
    && grep -qx "PASS: all tests" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- src.f
+incdir+common
common/rv_pkg.sv
hdl/fetch_stage.sv
hdl/trap_ctrl.sv
core/exec_unit.sv
hdl/riscv64_top.sv
tb/tb_clock.sv
tb/tb_riscv64.sv

//--- tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset  // Active low
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;  // First rising edge at half a period
    end

    // Reset held over a few rising edges, released on an edge
    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;
    end

endmodule

`default_nettype wire

//--- tb/tb_riscv64.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module tb_riscv64;
    import rv_pkg::*;

    localparam int CLK_PERIOD_NS = 100;
    localparam int LUI_ROUNDS    = 8;   // Random rounds before the x0 round

    // Cycle budget per test for the watchdog
    localparam int RESET_CYCLES  = 4;
    localparam int FREE_CYCLES   = 16;
    localparam int LUI_CYCLES    = (LUI_ROUNDS + 1) * 5;
    localparam int IRQ_CYCLES    = 14;
    localparam int RET_CYCLES    = 15;
    localparam int MARGIN_CYCLES = 40;
    localparam int WATCHDOG_NS   = (RESET_CYCLES + FREE_CYCLES + LUI_CYCLES + IRQ_CYCLES
                                    + RET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;

    localparam logic [31:0] NOP_WORD = 32'h0000_0013;  // Opcode 0010011 is not decoded
    localparam logic [31:0] RET_WORD = 32'h0000_0000;

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [3:0]  irq_vector;
    logic [31:0] pc;
    logic        heartbeat;
    bus_req_t    bus;

    string       test_name;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] exp_pc;      // Reference PC that steps by 4 unless a jump
    logic [31:0] saved_pc;    // Where the return word should land
    logic [4:0]  last_rd;     // Last random LUI target
    logic [63:0] last_val;    // and the value it holds
    logic [31:0] lfsr_state;

    tb_clock #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (3)
    ) clock_i (
        .clk   (clk),
        .reset (reset)
    );

    riscv64_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .irq_vector  (irq_vector),
        .pc          (pc),
        .heartbeat   (heartbeat),
        .bus         (bus)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // Source register in rs2 with all-ones opcode
    function automatic logic [31:0] put_word(input logic [4:0] rs2);
        return {7'd0, rs2, 13'd0, 7'b1111111};
    endfunction

    // Immediate shifted up by 12 then sign extended from bit 31
    function automatic logic [63:0] lui_value(input logic [19:0] imm);
        logic [31:0] shifted;
        shifted = 32'(imm) << 12;
        return 64'($signed(shifted));
    endfunction

    // New inputs on the rising edge and samples at the falling edge
    task automatic drive_cycle(input logic [31:0] instr, input logic [3:0] vec);
        @(posedge clk);
        instruction <= instr;
        irq_vector  <= vec;
        @(negedge clk);
        exp_pc = exp_pc + 32'd4;  // Sequential step that tests override on jumps
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_pc();
        check_value("pc", 64'(exp_pc), 64'(pc));
    endtask

    // Strobe level plus address and data while it is high
    task automatic check_bus(input logic exp_we, input logic [63:0] exp_data);
        check_value("write_enable", 64'(exp_we), 64'(bus.write_enable));
        if (exp_we && bus.write_enable) begin
            check_value("address", `RV_CONSOLE_ADDR, bus.address);
            check_value("write_data", exp_data, bus.write_data);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s finished, %0d error(s)", test_name, test_errors);
    endtask

    task automatic reset_state();
        begin_test("reset_state");
        exp_pc = `RV_RESET_PC;
        repeat (2) begin  // Inside reset
            @(negedge clk);
            check_pc();
            check_bus(1'b0, 64'd0);
            check_value("heartbeat", 64'd0, 64'(heartbeat));
        end
        wait (reset === 1'b1);
        @(negedge clk);  // First sample after release
        check_pc();
        check_bus(1'b0, 64'd0);
        check_value("heartbeat", 64'd0, 64'(heartbeat));
        finish_test();
    endtask

    task automatic free_run();
        logic exp_beat;
        begin_test("free_run");
        exp_beat = 1'b0;  // Heartbeat leaves reset low
        repeat (FREE_CYCLES) begin
            drive_cycle(NOP_WORD, 4'd0);
            exp_beat = ~exp_beat;
            check_pc();
            check_value("heartbeat", 64'(exp_beat), 64'(heartbeat));
            check_bus(1'b0, 64'd0);
        end
        finish_test();
    endtask

    task automatic lui_then_put();
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [63:0] exp_data;
        begin_test("lui_then_put");
        for (int round = 0; round <= LUI_ROUNDS; round++) begin
            imm = 20'(rand_bits(20));
            if (round == LUI_ROUNDS) begin
                rd       = 5'd0;  // Write dropped since x0 reads zero
                exp_data = 64'd0;
            end else begin
                rd = 5'(rand_bits(5));
                while (rd == 5'd0) begin
                    rd = 5'(rand_bits(5));
                end
                exp_data = lui_value(imm);
                last_rd  = rd;
                last_val = exp_data;
            end
            drive_cycle(lui_word(imm, rd), 4'd0);
            check_bus(1'b0, 64'd0);
            drive_cycle(put_word(rd), 4'd0);
            check_bus(1'b0, 64'd0);
            drive_cycle(NOP_WORD, 4'd0);
            check_bus(1'b0, 64'd0);    // Put sits in IR
            drive_cycle(NOP_WORD, 4'd0);
            check_bus(1'b1, exp_data);
            drive_cycle(NOP_WORD, 4'd0);
            check_bus(1'b0, 64'd0);    // Single cycle strobe
            check_pc();
        end
        finish_test();
    endtask

    task automatic interrupt_entry();
        logic [3:0] vec;
        begin_test("interrupt_entry");
        // Other vector values never taken
        repeat (6) begin
            vec = 4'(rand_bits(4));
            while (vec == `RV_IRQ_LINE) begin
                vec = 4'(rand_bits(4));
            end
            drive_cycle(NOP_WORD, vec);
            check_pc();
        end
        drive_cycle(put_word(last_rd), `RV_IRQ_LINE);  // Put lands in the bubble
        check_pc();
        saved_pc = exp_pc;  // PC at the taking edge
        drive_cycle(NOP_WORD, `RV_IRQ_LINE);
        exp_pc = `RV_TRAP_VECTOR;
        check_pc();
        check_bus(1'b0, 64'd0);
        // Pending blocks a second entry on a held vector
        repeat (6) begin
            drive_cycle(NOP_WORD, `RV_IRQ_LINE);
            check_pc();
            check_bus(1'b0, 64'd0);
        end
        finish_test();
    endtask

    task automatic return_and_ack();
        begin_test("return_and_ack");
        drive_cycle(put_word(5'd0), 4'd0);  // Acknowledge
        check_pc();
        drive_cycle(NOP_WORD, 4'd0);
        check_bus(1'b0, 64'd0);
        drive_cycle(NOP_WORD, 4'd0);
        check_bus(1'b1, 64'd0);
        drive_cycle(RET_WORD, 4'd0);
        check_bus(1'b0, 64'd0);
        drive_cycle(put_word(last_rd), 4'd0);  // Discarded by the bubble
        check_pc();
        drive_cycle(put_word(last_rd), 4'd0);  // First word after the bubble
        exp_pc = saved_pc;
        check_pc();
        drive_cycle(NOP_WORD, 4'd0);
        check_pc();
        check_bus(1'b0, 64'd0);
        drive_cycle(NOP_WORD, 4'd0);
        check_bus(1'b1, last_val);
        drive_cycle(NOP_WORD, 4'd0);
        check_bus(1'b0, 64'd0);
        // Second entry after acknowledge
        drive_cycle(NOP_WORD, `RV_IRQ_LINE);
        check_pc();
        drive_cycle(NOP_WORD, 4'd0);
        exp_pc = `RV_TRAP_VECTOR;
        check_pc();
        drive_cycle(put_word(5'd0), 4'd0);  // Closes the second interrupt
        drive_cycle(NOP_WORD, 4'd0);
        drive_cycle(NOP_WORD, 4'd0);
        check_bus(1'b1, 64'd0);
        drive_cycle(NOP_WORD, 4'd0);
        check_pc();
        finish_test();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        instruction  = NOP_WORD;
        irq_vector   = 4'd0;
        lfsr_state   = 32'hca44_961d;
        exp_pc       = `RV_RESET_PC;
        saved_pc     = 32'd0;
        last_rd      = 5'd0;
        last_val     = 64'd0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;

        reset_state();
        free_run();
        lui_then_put();
        interrupt_entry();
        return_and_ack();

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
